// File: Bender.yml
package:
  name: nf_inter_packet_delay

sources:
  - source/ipd_pkg.sv
  - source/ipd_axil_regs.sv
  - source/ipd_ingress.sv
  - source/ipd_gap_ctrl.sv
  - source/ipd_egress.sv
  - source/nf_inter_packet_delay.sv
  - target: test
    files:
      - sim/ipd_props.sv
      - sim/tb_ipd.sv

// File: files.f
source/ipd_pkg.sv
source/ipd_axil_regs.sv
source/ipd_ingress.sv
source/ipd_gap_ctrl.sv
source/ipd_egress.sv
source/nf_inter_packet_delay.sv
sim/ipd_props.sv
sim/tb_ipd.sv

// File: sim/ipd_props.sv
// Concurrent assertions on the pacer ports for handshake stability and output gaps
`timescale 1ns/1ns

module ipd_props import ipd_pkg::*; (
  input logic               axi_aclk,
  input logic               rst_n,
  input logic               s_axi_awready,
  input logic               s_axi_arready,
  input logic               s_axi_bvalid,
  input logic               s_axi_bready,
  input logic               s_axi_rvalid,
  input logic               s_axi_rready,
  input logic [data_w-1:0]  m_axis_tdata,
  input logic [keep_w-1:0]  m_axis_tkeep,
  input logic [tuser_w-1:0] m_axis_tuser,
  input logic               m_axis_tvalid,
  input logic               m_axis_tlast,
  input logic               m_axis_tready
);

  logic        fail_seen = 1'b0;
  logic [31:0] exp_gap = '0;
  logic        gap_check_en = 1'b0;
  logic        gap_exact = 1'b0;
  logic        after_last;
  logic [31:0] idle_cnt;

  // Idle cycles at the output since the last beat of the previous packet
  always_ff @(posedge axi_aclk) begin
    if (!rst_n) begin
      after_last <= 1'b0;
      idle_cnt   <= '0;
    end else if (m_axis_tvalid && m_axis_tready && m_axis_tlast) begin
      after_last <= 1'b1;
      idle_cnt   <= '0;
    end else if (m_axis_tvalid) begin
      after_last <= 1'b0;
    end else if (after_last) begin
      idle_cnt <= idle_cnt + 1'b1;
    end
  end

  a_hold_beat: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata) &&
      $stable(m_axis_tkeep) && $stable(m_axis_tuser) && $stable(m_axis_tlast))
    else begin
      $error("m_axis beat changed while stalled");
      fail_seen = 1'b1;
    end

  a_hold_b: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    (s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid) and (s_axi_awready |=> s_axi_bvalid))
    else begin
      $error("write response broke the one-outstanding rule");
      fail_seen = 1'b1;
    end

  a_hold_r: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    (s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid) and (s_axi_arready |=> s_axi_rvalid))
    else begin
      $error("read response broke the one-outstanding rule");
      fail_seen = 1'b1;
    end

  a_min_gap: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    gap_check_en && after_last && m_axis_tvalid |-> idle_cnt >= exp_gap)
    else begin
      $error("gap %0d below expected %0d", idle_cnt, exp_gap);
      fail_seen = 1'b1;
    end

  a_exact_gap: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    gap_check_en && gap_exact && after_last && m_axis_tvalid |-> idle_cnt == exp_gap)
    else begin
      $error("gap %0d differs from expected %0d", idle_cnt, exp_gap);
      fail_seen = 1'b1;
    end

endmodule

bind nf_inter_packet_delay ipd_props props_i (.*);

// File: sim/tb_ipd.sv
// Testbench for the pacer with clock, reset, AXI-lite tasks, packet stimulus, scoreboard and watchdog
`timescale 1ns/1ns

module tb_ipd import ipd_pkg::*; ();

  localparam int n_pt      = 6;
  localparam int n_reg     = 6;
  localparam int n_ts      = 6;
  localparam int n_bp      = 8;
  localparam int reg_gap   = 6;
  localparam int min_step  = 16;
  localparam int max_step  = min_step + 15;
  localparam int sw_gap    = 1000;
  localparam int n_total   = n_pt + n_reg + n_ts + n_bp + 2;
  localparam int wd_limit  = 200 * n_total + n_reg * reg_gap + n_ts * max_step;

  // AXI OKAY response code
  localparam logic [1:0] okay_resp = 2'b00;

  logic                   axi_aclk = 1'b0;
  logic                   rst_n;
  logic [axil_addr_w-1:0] s_axi_awaddr;
  logic                   s_axi_awvalid;
  logic                   s_axi_awready;
  logic [axil_data_w-1:0] s_axi_wdata;
  logic                   s_axi_wvalid;
  logic                   s_axi_wready;
  logic [1:0]             s_axi_bresp;
  logic                   s_axi_bvalid;
  logic                   s_axi_bready;
  logic [axil_addr_w-1:0] s_axi_araddr;
  logic                   s_axi_arvalid;
  logic                   s_axi_arready;
  logic [axil_data_w-1:0] s_axi_rdata;
  logic [1:0]             s_axi_rresp;
  logic                   s_axi_rvalid;
  logic                   s_axi_rready;
  logic [data_w-1:0]      s_axis_tdata;
  logic [keep_w-1:0]      s_axis_tkeep;
  logic [tuser_w-1:0]     s_axis_tuser;
  logic                   s_axis_tvalid;
  logic                   s_axis_tlast;
  logic                   s_axis_tready;
  logic [data_w-1:0]      m_axis_tdata;
  logic [keep_w-1:0]      m_axis_tkeep;
  logic [tuser_w-1:0]     m_axis_tuser;
  logic                   m_axis_tvalid;
  logic                   m_axis_tlast;
  logic                   m_axis_tready;

  axis_beat_t      exp_q [$];
  axis_beat_t      exp_beat;
  logic [31:0]     lfsr_q  = 32'h769db24a;
  logic [31:0]     stall_q = 32'h769db24a;
  logic            stall_en = 1'b0;
  int              pkts_sent = 0;

  nf_inter_packet_delay dut_i (.*);

  always #5 axi_aclk = ~axi_aclk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] next_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic report_fail(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic value_fail(input string name, input logic [63:0] exp, input logic [63:0] got);
    $display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, got);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic axil_write(input logic [axil_addr_w-1:0] addr, input logic [31:0] data);
    int n;
    @(negedge axi_aclk);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    n = 0;
    do begin
      @(posedge axi_aclk);
      n++;
    end while (!s_axi_awready && n < 50);
    assert (s_axi_awready && s_axi_wready) else report_fail("AXI-lite write was never accepted");
    // Request stays up one more cycle and must not be taken while the response waits
    @(posedge axi_aclk);
    assert (!s_axi_awready && !s_axi_wready)
      else report_fail("AXI-lite write accepted while a response was pending");
    @(negedge axi_aclk);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    n = 0;
    while (!s_axi_bvalid && n < 50) begin
      @(posedge axi_aclk);
      n++;
    end
    assert (s_axi_bvalid) else report_fail("AXI-lite write response never arrived");
    assert (s_axi_bresp === okay_resp)
      else value_fail("s_axi_bresp", 64'(okay_resp), 64'(s_axi_bresp));
    // One cycle with bready low so bvalid must hold
    @(negedge axi_aclk);
    s_axi_bready = 1'b1;
    @(negedge axi_aclk);
    s_axi_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [axil_addr_w-1:0] addr, input logic [31:0] exp);
    int n;
    @(negedge axi_aclk);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    n = 0;
    do begin
      @(posedge axi_aclk);
      n++;
    end while (!s_axi_arready && n < 50);
    assert (s_axi_arready) else report_fail("AXI-lite read was never accepted");
    // Request stays up one more cycle and must not be taken while read data waits
    @(posedge axi_aclk);
    assert (!s_axi_arready) else report_fail("AXI-lite read accepted while read data was pending");
    @(negedge axi_aclk);
    s_axi_arvalid = 1'b0;
    n = 0;
    while (!s_axi_rvalid && n < 50) begin
      @(posedge axi_aclk);
      n++;
    end
    assert (s_axi_rvalid) else report_fail("AXI-lite read data never arrived");
    assert (s_axi_rdata === exp) else value_fail("s_axi_rdata", exp, s_axi_rdata);
    assert (s_axi_rresp === okay_resp)
      else value_fail("s_axi_rresp", 64'(okay_resp), 64'(s_axi_rresp));
    @(negedge axi_aclk);
    s_axi_rready = 1'b1;
    @(negedge axi_aclk);
    s_axi_rready = 1'b0;
  endtask

  task automatic send_pkt(input int len, input logic [ts_w-1:0] ts);
    axis_beat_t b;
    for (int i = 0; i < len; i++) begin
      b.data  = next_bits(64);
      b.keep  = (i == len - 1) ? (keep_w'(next_bits(8)) | 8'h01) : '1;
      b.tuser = {ts, 32'(next_bits(32))};
      b.last  = (i == len - 1);
      @(negedge axi_aclk);
      s_axis_tdata  = b.data;
      s_axis_tkeep  = b.keep;
      s_axis_tuser  = b.tuser;
      s_axis_tlast  = b.last;
      s_axis_tvalid = 1'b1;
      do @(posedge axi_aclk); while (!s_axis_tready);
      exp_q.push_back(b);
    end
    pkts_sent++;
  endtask

  task automatic stop_input();
    @(negedge axi_aclk);
    s_axis_tvalid = 1'b0;
  endtask

  task automatic wait_drained();
    do @(negedge axi_aclk); while (exp_q.size() != 0 || m_axis_tvalid);
    repeat (3) @(negedge axi_aclk);
  endtask

  // Random back-pressure on the master stream
  always @(negedge axi_aclk) begin
    if (stall_en) begin
      stall_q = lfsr_next(stall_q);
      m_axis_tready = stall_q[0];
    end else begin
      m_axis_tready = 1'b1;
    end
  end

  // Scoreboard on the master stream
  always @(posedge axi_aclk) begin
    if (rst_n && m_axis_tvalid && m_axis_tready) begin
      assert (exp_q.size() > 0) else report_fail("Output beat with no beat outstanding");
      exp_beat = exp_q.pop_front();
      assert (m_axis_tdata === exp_beat.data)
        else value_fail("m_axis_tdata", exp_beat.data, m_axis_tdata);
      assert (m_axis_tkeep === exp_beat.keep)
        else value_fail("m_axis_tkeep", 64'(exp_beat.keep), 64'(m_axis_tkeep));
      assert (m_axis_tuser === exp_beat.tuser)
        else value_fail("m_axis_tuser", exp_beat.tuser, m_axis_tuser);
      assert (m_axis_tlast === exp_beat.last)
        else value_fail("m_axis_tlast", 64'(exp_beat.last), 64'(m_axis_tlast));
    end
  end

  always @(posedge axi_aclk) begin
    if (dut_i.props_i.fail_seen) report_fail("A concurrent assertion on the DUT ports failed");
  end

  initial begin
    repeat (wd_limit) @(posedge axi_aclk);
    $display("Timeout: run did not finish within %0d cycles", wd_limit);
    $display("Checks failed");
    $fatal(1);
  end

  initial begin
    logic [ts_w-1:0] ts;
    logic [ts_w-1:0] prev_ts;
    int              lat;
    rst_n = 1'b0;
    s_axi_awaddr = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata = '0;
    s_axi_wvalid = 1'b0;
    s_axi_bready = 1'b0;
    s_axi_araddr = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready = 1'b0;
    s_axis_tdata = '0;
    s_axis_tkeep = '0;
    s_axis_tuser = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
    m_axis_tready = 1'b1;
    dut_i.props_i.exp_gap = '0;
    dut_i.props_i.gap_check_en = 1'b0;
    dut_i.props_i.gap_exact = 1'b0;
    repeat (8) @(posedge axi_aclk);
    @(negedge axi_aclk);
    rst_n = 1'b1;

    // Registers after reset and readback
    axil_read(reg_ctrl, 32'h0);
    axil_read(reg_delay, 32'h0);
    axil_read(reg_pkt_cnt, 32'h0);
    axil_write(reg_delay, 32'ha5c3_0011);
    axil_read(reg_delay, 32'ha5c3_0011);
    axil_write(reg_ctrl, 32'h6);
    axil_read(reg_ctrl, 32'h6);
    axil_write(reg_ctrl, 32'h0);
    axil_read(reg_ctrl, 32'h0);

    // Pass-through at full rate leaves no idle cycle between packets
    dut_i.props_i.exp_gap = '0;
    dut_i.props_i.gap_exact = 1'b1;
    dut_i.props_i.gap_check_en = 1'b1;
    for (int i = 0; i < n_pt; i++) send_pkt(1 + int'(next_bits(3)), ts_w'(next_bits(32)));
    stop_input();
    wait_drained();
    dut_i.props_i.gap_check_en = 1'b0;
    dut_i.props_i.gap_exact = 1'b0;
    axil_read(reg_pkt_cnt, 32'(pkts_sent));

    // Register gap is exact once the first packet has left
    axil_write(reg_delay, 32'(reg_gap));
    axil_write(reg_ctrl, 32'h6);
    fork
      begin
        for (int i = 0; i < n_reg; i++) send_pkt(1 + int'(next_bits(3)), '0);
        stop_input();
      end
      begin
        @(posedge axi_aclk iff (m_axis_tvalid && m_axis_tready && m_axis_tlast));
        @(negedge axi_aclk);
        dut_i.props_i.exp_gap = 32'(reg_gap);
        dut_i.props_i.gap_exact = 1'b1;
        dut_i.props_i.gap_check_en = 1'b1;
      end
    join
    wait_drained();
    dut_i.props_i.gap_check_en = 1'b0;
    dut_i.props_i.gap_exact = 1'b0;

    // First timestamp packet after enable owes no gap
    axil_write(reg_ctrl, 32'h0);
    axil_write(reg_ctrl, 32'h2);
    // Start near the top so the second step wraps
    ts = 32'hffff_ffe0;
    prev_ts = ts;
    for (int i = 0; i < n_ts; i++) begin
      ts = ts + ts_w'(min_step + next_bits(4));
      dut_i.props_i.exp_gap = ts - prev_ts;
      dut_i.props_i.gap_check_en = (i > 0);
      send_pkt(1 + int'(next_bits(3)), ts);
      stop_input();
      wait_drained();
      prev_ts = ts;
    end
    dut_i.props_i.gap_check_en = 1'b0;

    // Back-pressure
    axil_write(reg_ctrl, 32'h0);
    stall_en = 1'b1;
    for (int i = 0; i < n_bp; i++) send_pkt(1 + int'(next_bits(3)), ts_w'(next_bits(32)));
    stop_input();
    wait_drained();
    stall_en = 1'b0;
    axil_read(reg_pkt_cnt, 32'(pkts_sent));

    // Long gap left pending ahead of the software reset
    axil_write(reg_delay, 32'(sw_gap));
    axil_write(reg_ctrl, 32'h6);
    send_pkt(1 + int'(next_bits(3)), '0);
    stop_input();
    wait_drained();

    // Software reset clears the count and the next packet leaves without a gap
    axil_write(reg_ctrl, 32'h7);
    axil_write(reg_ctrl, 32'h6);
    axil_read(reg_pkt_cnt, 32'h0);
    axil_read(reg_ctrl, 32'h6);
    lat = 0;
    fork
      send_pkt(3, '0);
      begin
        @(posedge axi_aclk iff (s_axis_tvalid && s_axis_tready));
        do begin
          @(posedge axi_aclk);
          lat++;
        end while (!m_axis_tvalid && lat < 50);
      end
    join
    assert (lat == 2) else value_fail("first beat latency", 64'd2, 64'(lat));
    stop_input();
    wait_drained();
    axil_read(reg_pkt_cnt, 32'h1);

    assert (exp_q.size() == 0) else report_fail("Beats sent but never seen at the output");
    if (dut_i.props_i.fail_seen) begin
      $display("Checks failed");
      $fatal(1);
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

// File: source/ipd_axil_regs.sv
// AXI-lite slave with control and delay registers and packet count readback
`timescale 1ns/1ns

module ipd_axil_regs import ipd_pkg::*; (
  input  logic                   axi_aclk,
  input  logic                   rst_n,
  input  logic [axil_addr_w-1:0] s_axi_awaddr,
  input  logic                   s_axi_awvalid,
  output logic                   s_axi_awready,
  input  logic [axil_data_w-1:0] s_axi_wdata,
  input  logic                   s_axi_wvalid,
  output logic                   s_axi_wready,
  output logic [1:0]             s_axi_bresp,
  output logic                   s_axi_bvalid,
  input  logic                   s_axi_bready,
  input  logic [axil_addr_w-1:0] s_axi_araddr,
  input  logic                   s_axi_arvalid,
  output logic                   s_axi_arready,
  output logic [axil_data_w-1:0] s_axi_rdata,
  output logic [1:0]             s_axi_rresp,
  output logic                   s_axi_rvalid,
  input  logic                   s_axi_rready,
  input  logic [axil_data_w-1:0] pkt_cnt,
  output ipd_ctrl_t              ctrl
);

  logic      wr_go;
  logic      rd_go;
  ipd_ctrl_t ctrl_q;

  // Address and data must both be present, one response outstanding at most
  assign wr_go = s_axi_awvalid & s_axi_wvalid & ~s_axi_bvalid;
  assign rd_go = s_axi_arvalid & ~s_axi_rvalid;

  assign s_axi_awready = wr_go;
  assign s_axi_wready  = wr_go;
  assign s_axi_arready = rd_go;
  assign s_axi_bresp   = axi_resp_okay;
  assign s_axi_rresp   = axi_resp_okay;
  assign ctrl          = ctrl_q;

  // Register writes and write response
  always_ff @(posedge axi_aclk) begin
    if (!rst_n) begin
      ctrl_q       <= '0;
      s_axi_bvalid <= 1'b0;
    end else begin
      if (wr_go) begin
        s_axi_bvalid <= 1'b1;
        case (reg_addr_e'(s_axi_awaddr))
          reg_ctrl: begin
            ctrl_q.sw_rst      <= s_axi_wdata[0];
            ctrl_q.ipd_en      <= s_axi_wdata[1];
            ctrl_q.use_reg_val <= s_axi_wdata[2];
          end
          reg_delay: ctrl_q.delay_val <= s_axi_wdata;
          // Count register is read only
          default: ;
        endcase
      end else if (s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
    end
  end

  // Read response handshake
  always_ff @(posedge axi_aclk) begin
    if (!rst_n) begin
      s_axi_rvalid <= 1'b0;
    end else if (rd_go) begin
      s_axi_rvalid <= 1'b1;
    end else if (s_axi_rready) begin
      s_axi_rvalid <= 1'b0;
    end
  end

  // Read data capture, unmapped addresses return zero
  always_ff @(posedge axi_aclk) begin
    if (rd_go) begin
      case (reg_addr_e'(s_axi_araddr))
        reg_ctrl: begin
          s_axi_rdata <= {{(axil_data_w-3){1'b0}},
                          ctrl_q.use_reg_val, ctrl_q.ipd_en, ctrl_q.sw_rst};
        end
        reg_delay:   s_axi_rdata <= ctrl_q.delay_val;
        reg_pkt_cnt: s_axi_rdata <= pkt_cnt;
        default:     s_axi_rdata <= '0;
      endcase
    end
  end

endmodule

// File: source/ipd_egress.sv
// Egress register slice toward the master stream with sent-packet counter
`timescale 1ns/1ns

module ipd_egress import ipd_pkg::*; (
  input  logic                   axi_aclk,
  input  logic                   rst_n,
  input  ipd_ctrl_t              ctrl,
  input  axis_beat_t             in_beat,
  input  logic                   in_valid,
  output logic                   in_ready,
  output logic [data_w-1:0]      m_axis_tdata,
  output logic [keep_w-1:0]      m_axis_tkeep,
  output logic [tuser_w-1:0]     m_axis_tuser,
  output logic                   m_axis_tvalid,
  output logic                   m_axis_tlast,
  input  logic                   m_axis_tready,
  output logic [axil_data_w-1:0] pkt_cnt
);

  axis_beat_t main_q;
  axis_beat_t skid_q;
  logic       main_vld_q;
  logic       skid_vld_q;
  logic       in_fire;
  logic       out_fire;

  assign in_ready = ~skid_vld_q;
  assign in_fire  = in_valid & in_ready;
  assign out_fire = main_vld_q & m_axis_tready;

  assign m_axis_tdata  = main_q.data;
  assign m_axis_tkeep  = main_q.keep;
  assign m_axis_tuser  = main_q.tuser;
  assign m_axis_tlast  = main_q.last;
  assign m_axis_tvalid = main_vld_q;

  always_ff @(posedge axi_aclk) begin
    if (!rst_n) begin
      main_vld_q <= 1'b0;
      skid_vld_q <= 1'b0;
    end else if (!main_vld_q || out_fire) begin
      // Main slot free this cycle, refill from skid first
      main_vld_q <= skid_vld_q | in_fire;
      skid_vld_q <= 1'b0;
    end else if (in_fire) begin
      skid_vld_q <= 1'b1;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (!main_vld_q || out_fire) begin
      main_q <= skid_vld_q ? skid_q : in_beat;
    end else if (in_fire) begin
      skid_q <= in_beat;
    end
  end

  // Packets completed at the master port
  always_ff @(posedge axi_aclk) begin
    if (!rst_n || ctrl.sw_rst) begin
      pkt_cnt <= '0;
    end else if (out_fire && main_q.last) begin
      pkt_cnt <= pkt_cnt + 1'b1;
    end
  end

endmodule

// File: source/ipd_gap_ctrl.sv
// Pacing FSM that enforces the idle gap between consecutive packets
`timescale 1ns/1ns

module ipd_gap_ctrl import ipd_pkg::*; (
  input  logic            axi_aclk,
  input  logic            rst_n,
  input  ipd_ctrl_t       ctrl,
  input  axis_beat_t      in_beat,
  input  logic            in_valid,
  input  logic            in_first,
  input  logic [ts_w-1:0] in_ts,
  output logic            in_ready,
  output axis_beat_t      out_beat,
  output logic            out_valid,
  input  logic            out_ready
);

  gap_state_e             state_q;
  logic [ts_w-1:0]        prev_ts_q;
  logic                   first_pkt_q;
  logic [axil_data_w-1:0] elapsed_q;
  logic [axil_data_w-1:0] gap_cyc;
  logic                   open;
  logic                   in_fire;

  // Gap owed by the beat now presented
  always_comb begin
    if (!ctrl.ipd_en || first_pkt_q || !in_first) begin
      gap_cyc = '0;
    end else if (ctrl.use_reg_val) begin
      gap_cyc = ctrl.delay_val;
    end else begin
      // Wraps modulo 2^32
      gap_cyc = in_ts - prev_ts_q;
    end
  end

  // Elapsed count runs from the cycle after the last beat
  assign open    = (state_q == gs_pass) || (elapsed_q >= gap_cyc);
  assign in_fire = in_valid & in_ready;

  assign out_beat  = in_beat;
  assign out_valid = in_valid & open;
  assign in_ready  = out_ready & open;

  always_ff @(posedge axi_aclk) begin
    if (!rst_n || ctrl.sw_rst) begin
      state_q     <= gs_pass;
      first_pkt_q <= 1'b1;
      elapsed_q   <= '0;
    end else if (!ctrl.ipd_en) begin
      state_q     <= gs_pass;
      first_pkt_q <= 1'b1;
      elapsed_q   <= '0;
    end else begin
      if (in_fire && in_first) first_pkt_q <= 1'b0;
      if (in_fire && in_beat.last) begin
        state_q   <= gs_wait;
        elapsed_q <= '0;
      end else if (in_fire) begin
        state_q <= gs_pass;
      end else if (state_q == gs_wait && elapsed_q != '1) begin
        // Saturate instead of wrapping on very long idle periods
        elapsed_q <= elapsed_q + 1'b1;
      end
    end
  end

  // Timestamp of the most recent first beat
  always_ff @(posedge axi_aclk) begin
    if (!rst_n || ctrl.sw_rst) begin
      prev_ts_q <= '0;
    end else if (in_fire && in_first) begin
      prev_ts_q <= in_ts;
    end
  end

endmodule

// File: source/ipd_ingress.sv
// Ingress skid buffer with first-beat marking and timestamp extraction
`timescale 1ns/1ns

module ipd_ingress import ipd_pkg::*; (
  input  logic               axi_aclk,
  input  logic               rst_n,
  input  logic [data_w-1:0]  s_axis_tdata,
  input  logic [keep_w-1:0]  s_axis_tkeep,
  input  logic [tuser_w-1:0] s_axis_tuser,
  input  logic               s_axis_tvalid,
  input  logic               s_axis_tlast,
  output logic               s_axis_tready,
  output axis_beat_t         out_beat,
  output logic               out_valid,
  output logic               out_first,
  output logic [ts_w-1:0]    out_ts,
  input  logic               out_ready
);

  axis_beat_t beat_mem [2];
  logic       first_mem [2];
  logic [1:0] cnt_q;
  logic [1:0] cnt_next;
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic       ready_q;
  logic       in_pkt_q;
  logic       in_fire;
  logic       out_fire;

  assign in_fire  = s_axis_tvalid & ready_q;
  assign out_fire = out_valid & out_ready;
  assign cnt_next = cnt_q + 2'(in_fire) - 2'(out_fire);

  assign s_axis_tready = ready_q;
  assign out_valid     = (cnt_q != 2'd0);
  assign out_beat      = beat_mem[rd_ptr_q];
  assign out_first     = first_mem[rd_ptr_q];
  assign out_ts        = out_beat.tuser[ts_pos +: ts_w];

  // Ready is low for the first cycle out of reset, then tracks free entries
  always_ff @(posedge axi_aclk) begin
    if (!rst_n) begin
      cnt_q    <= 2'd0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      ready_q  <= 1'b0;
      in_pkt_q <= 1'b0;
    end else begin
      cnt_q   <= cnt_next;
      ready_q <= (cnt_next != 2'd2);
      if (in_fire) begin
        wr_ptr_q <= ~wr_ptr_q;
        in_pkt_q <= ~s_axis_tlast;
      end
      if (out_fire) rd_ptr_q <= ~rd_ptr_q;
    end
  end

  // Entry storage
  always_ff @(posedge axi_aclk) begin
    if (in_fire) begin
      beat_mem[wr_ptr_q]  <= '{data: s_axis_tdata, keep: s_axis_tkeep,
                               tuser: s_axis_tuser, last: s_axis_tlast};
      first_mem[wr_ptr_q] <= ~in_pkt_q;
    end
  end

endmodule

// File: source/ipd_pkg.sv
// Pacer widths, register map, control and stream beat structs, pacing states
package ipd_pkg;

  // Stream widths
  localparam int data_w  = 64;
  localparam int keep_w  = data_w / 8;
  localparam int tuser_w = 64;

  // Timestamp field inside tuser
  localparam int ts_pos = 32;
  localparam int ts_w   = 32;

  // AXI-lite register port
  localparam int axil_data_w = 32;
  localparam int axil_addr_w = 4;

  localparam logic [1:0] axi_resp_okay = 2'b00;

  // Register map, byte addresses
  typedef enum logic [axil_addr_w-1:0] {
    reg_ctrl    = 4'h0,
    reg_delay   = 4'h4,
    reg_pkt_cnt = 4'h8
  } reg_addr_e;

  // Software control, fed to gap control and egress
  typedef struct packed {
    logic                   sw_rst;
    logic                   ipd_en;
    logic                   use_reg_val;
    logic [axil_data_w-1:0] delay_val;
  } ipd_ctrl_t;

  // One stream beat as carried between stages
  typedef struct packed {
    logic [data_w-1:0]  data;
    logic [keep_w-1:0]  keep;
    logic [tuser_w-1:0] tuser;
    logic               last;
  } axis_beat_t;

  typedef enum logic {
    gs_pass = 1'b0,
    gs_wait = 1'b1
  } gap_state_e;

endpackage

// File: source/nf_inter_packet_delay.sv
// Inter-packet delay top level joining registers, ingress, gap control and egress
`timescale 1ns/1ns

module nf_inter_packet_delay import ipd_pkg::*; (
  input  logic                   axi_aclk,
  input  logic                   rst_n,
  // AXI-lite register port
  input  logic [axil_addr_w-1:0] s_axi_awaddr,
  input  logic                   s_axi_awvalid,
  output logic                   s_axi_awready,
  input  logic [axil_data_w-1:0] s_axi_wdata,
  input  logic                   s_axi_wvalid,
  output logic                   s_axi_wready,
  output logic [1:0]             s_axi_bresp,
  output logic                   s_axi_bvalid,
  input  logic                   s_axi_bready,
  input  logic [axil_addr_w-1:0] s_axi_araddr,
  input  logic                   s_axi_arvalid,
  output logic                   s_axi_arready,
  output logic [axil_data_w-1:0] s_axi_rdata,
  output logic [1:0]             s_axi_rresp,
  output logic                   s_axi_rvalid,
  input  logic                   s_axi_rready,
  // Stream in
  input  logic [data_w-1:0]      s_axis_tdata,
  input  logic [keep_w-1:0]      s_axis_tkeep,
  input  logic [tuser_w-1:0]     s_axis_tuser,
  input  logic                   s_axis_tvalid,
  input  logic                   s_axis_tlast,
  output logic                   s_axis_tready,
  // Stream out
  output logic [data_w-1:0]      m_axis_tdata,
  output logic [keep_w-1:0]      m_axis_tkeep,
  output logic [tuser_w-1:0]     m_axis_tuser,
  output logic                   m_axis_tvalid,
  output logic                   m_axis_tlast,
  input  logic                   m_axis_tready
);

  ipd_ctrl_t              ctrl;
  logic [axil_data_w-1:0] pkt_cnt;

  axis_beat_t      ing_beat;
  logic            ing_valid;
  logic            ing_ready;
  logic            ing_first;
  logic [ts_w-1:0] ing_ts;

  axis_beat_t gap_beat;
  logic       gap_valid;
  logic       gap_ready;

  ipd_axil_regs regs_i (
    .axi_aclk      (axi_aclk),
    .rst_n         (rst_n),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .pkt_cnt       (pkt_cnt),
    .ctrl          (ctrl)
  );

  ipd_ingress ingress_i (
    .axi_aclk      (axi_aclk),
    .rst_n         (rst_n),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tkeep  (s_axis_tkeep),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .out_beat      (ing_beat),
    .out_valid     (ing_valid),
    .out_first     (ing_first),
    .out_ts        (ing_ts),
    .out_ready     (ing_ready)
  );

  ipd_gap_ctrl gap_i (
    .axi_aclk  (axi_aclk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .in_beat   (ing_beat),
    .in_valid  (ing_valid),
    .in_first  (ing_first),
    .in_ts     (ing_ts),
    .in_ready  (ing_ready),
    .out_beat  (gap_beat),
    .out_valid (gap_valid),
    .out_ready (gap_ready)
  );

  ipd_egress egress_i (
    .axi_aclk      (axi_aclk),
    .rst_n         (rst_n),
    .ctrl          (ctrl),
    .in_beat       (gap_beat),
    .in_valid      (gap_valid),
    .in_ready      (gap_ready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready),
    .pkt_cnt       (pkt_cnt)
  );

endmodule
